// ==== project.f ====
design/ccip_pkg.sv
design/sniff_pkg.sv
design/tx_decode.sv
design/request_rule_check.sv
design/c1_burst_check.sv
design/mmio_tracker.sv
design/error_report.sv
design/ccip_sniffer_top.sv
verif/sniffer_assertions.sv
verif/tb_sniffer.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

# Run from the project root so the golden file path resolves
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_sniffer -o sim_sniffer

# The verdict comes from the log, so a crashed run still gets searched
./obj_dir/sim_sniffer > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
   exit 0
else
   echo "pass line not found in sim.log"
   exit 1
fi

// ==== verif/sniffer_golden.txt ====
# sr f0 f1 | c0 valid type len addr | c1 valid type len sop vc addr | c2 valid tid
# mmio valid tid | expected error_code, expected sim_kill | all hex, one row per cycle
0 0 0 1 0 0 100 0 0 0 0 0 000 0 0 0 0 000000 0
0 0 0 1 1 1 102 0 0 0 0 0 000 0 0 0 0 000000 0
0 0 0 1 0 3 104 1 0 0 1 1 200 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 1 1 1 2 202 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 1 1 0 2 203 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 2 3 1 0 300 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 2 3 0 0 301 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 2 3 0 0 302 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 2 3 0 0 303 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 4 0 0 0 400 0 0 1 3 000000 0
0 0 0 0 0 0 000 0 0 0 0 0 000 0 0 0 0 000000 0
0 0 0 0 0 0 000 0 0 0 0 0 000 1 3 0 0 000000 0
1 0 0 1 0 0 120 0 0 0 0 0 000 0 0 0 0 000010 0
1 0 0 0 0 0 000 1 0 0 1 0 220 0 0 1 5 000800 0
0 0 0 0 0 0 000 0 0 0 0 0 000 0 0 0 0 000000 0
1 0 0 0 0 0 000 0 0 0 0 0 000 1 5 0 0 400000 0
0 0 0 1 0 0 000 0 0 0 0 0 000 0 0 0 0 000040 0
0 0 0 0 0 0 000 1 0 0 1 0 000 0 0 0 0 080000 0
0 0 0 0 0 0 000 1 0 1 1 1 210 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 0 1 0 3 211 0 0 0 0 001000 0
0 0 0 1 3 0 130 0 0 0 0 0 000 0 0 1 7 000001 0
0 0 0 1 0 2 130 0 0 0 0 0 000 0 0 0 0 000020 0
0 0 0 1 0 1 131 0 0 0 0 0 000 0 0 0 0 000004 0
0 0 0 1 0 3 132 0 0 0 0 0 000 0 0 0 0 000008 0
0 1 0 1 0 0 140 0 0 0 0 0 000 0 0 0 0 000002 0
0 0 1 0 0 0 000 1 0 0 1 0 240 0 0 0 0 000100 0
0 0 0 0 0 0 000 1 7 0 1 0 2b0 0 0 0 0 000080 0
0 0 0 0 0 0 000 1 0 0 0 0 250 0 0 0 0 008000 0
0 0 0 0 0 0 000 1 0 1 1 0 260 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 0 1 1 0 261 0 0 0 0 010000 0
0 0 0 0 0 0 000 1 0 1 1 0 270 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 1 1 0 0 271 0 0 0 0 004000 0
0 0 0 0 0 0 000 1 0 1 1 0 280 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 0 1 0 0 283 0 0 0 0 002000 0
0 0 0 0 0 0 000 1 0 3 1 0 290 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 0 3 0 0 291 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 4 0 0 0 292 0 0 0 0 140000 0
0 0 0 0 0 0 000 1 0 3 0 0 292 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 0 3 0 0 293 0 0 0 0 000000 0
0 0 0 0 0 0 000 1 0 2 1 0 2a0 0 0 0 0 020000 0
0 0 0 0 0 0 000 1 0 1 1 0 2c1 0 0 0 0 000200 1
0 0 0 0 0 0 000 1 0 1 0 0 2c2 0 0 0 0 000000 1
0 0 0 0 0 0 000 1 0 3 1 0 2d2 0 0 0 0 000400 1
0 0 0 0 0 0 000 1 0 3 0 0 2d3 0 0 0 0 000000 1
0 0 0 0 0 0 000 1 0 3 0 0 2d0 0 0 0 0 000000 1
0 0 0 0 0 0 000 1 0 3 0 0 2d1 0 0 0 0 000000 1
0 0 0 0 0 0 000 0 0 0 0 0 000 1 7 0 0 000000 1
0 0 0 0 0 0 000 0 0 0 0 0 000 1 7 0 0 200000 1
0 0 0 0 0 0 000 0 0 0 0 0 000 1 9 0 0 200000 1
0 0 0 0 0 0 000 0 0 0 0 0 000 0 0 0 0 000000 1

// ==== verif/tb_sniffer.sv ====
`timescale 1ns/1ps

module tb_sniffer import ccip_pkg::*; import sniff_pkg::*; ();

   // Golden table shape with one row per cycle
   localparam int MAX_LINES  = 128;
   localparam int NUM_FIELDS = 19;
   localparam int FIELD_ERR  = 17;
   localparam int FIELD_KILL = 18;

   logic                          clk;
   logic                          ase_reset;
   logic                          soft_reset;
   logic                          c0_realfull;
   logic                          c1_realfull;
   logic                          c0_valid;
   logic [CCIP_REQ_WIDTH-1:0]     c0_req_type;
   logic [CCIP_CLLEN_WIDTH-1:0]   c0_cl_len;
   logic [CCIP_CLADDR_WIDTH-1:0]  c0_addr;
   logic                          c1_valid;
   logic [CCIP_REQ_WIDTH-1:0]     c1_req_type;
   logic [CCIP_CLLEN_WIDTH-1:0]   c1_cl_len;
   logic                          c1_sop;
   logic [CCIP_VC_WIDTH-1:0]      c1_vc_sel;
   logic [CCIP_CLADDR_WIDTH-1:0]  c1_addr;
   logic                          c2_rsp_valid;
   logic [CCIP_TID_WIDTH-1:0]     c2_rsp_tid;
   logic                          mmio_req_valid;
   logic [CCIP_TID_WIDTH-1:0]     mmio_req_tid;
   logic [SNIFF_VECTOR_WIDTH-1:0] error_code;
   logic                          sim_kill;

   // Stimulus fields then expected error_code and sim_kill
   logic [63:0] golden [MAX_LINES][NUM_FIELDS];

   int error_count = 0;
   int check_count = 0;
   int cycle_count = 0;
   // Set to its real value once the golden length is known
   int cycle_limit = 1000;

   ccip_sniffer_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // Watchdog on clock cycles
   initial begin
      while (cycle_count <= cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, stimulus did not complete", cycle_count);
      $display("test failed");
      $finish;
   end

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected, input int line);
      check_count++;
      if (actual !== expected) begin
         $display("ERROR: %s mismatch, got 0x%0h expected 0x%0h (golden line %0d)",
                  name, actual, expected, line);
         error_count++;
      end
   endtask

   task automatic drive_idle();
      soft_reset     = 1'b0;
      c0_realfull    = 1'b0;
      c1_realfull    = 1'b0;
      c0_valid       = 1'b0;
      c0_req_type    = '0;
      c0_cl_len      = '0;
      c0_addr        = '0;
      c1_valid       = 1'b0;
      c1_req_type    = '0;
      c1_cl_len      = '0;
      c1_sop         = 1'b0;
      c1_vc_sel      = '0;
      c1_addr        = '0;
      c2_rsp_valid   = 1'b0;
      c2_rsp_tid     = '0;
      mmio_req_valid = 1'b0;
      mmio_req_tid   = '0;
   endtask

   // Column order as in the golden file header
   task automatic apply_line(input int n);
      soft_reset     = golden[n][0][0];
      c0_realfull    = golden[n][1][0];
      c1_realfull    = golden[n][2][0];
      c0_valid       = golden[n][3][0];
      c0_req_type    = golden[n][4][CCIP_REQ_WIDTH-1:0];
      c0_cl_len      = golden[n][5][CCIP_CLLEN_WIDTH-1:0];
      c0_addr        = golden[n][6][CCIP_CLADDR_WIDTH-1:0];
      c1_valid       = golden[n][7][0];
      c1_req_type    = golden[n][8][CCIP_REQ_WIDTH-1:0];
      c1_cl_len      = golden[n][9][CCIP_CLLEN_WIDTH-1:0];
      c1_sop         = golden[n][10][0];
      c1_vc_sel      = golden[n][11][CCIP_VC_WIDTH-1:0];
      c1_addr        = golden[n][12][CCIP_CLADDR_WIDTH-1:0];
      c2_rsp_valid   = golden[n][13][0];
      c2_rsp_tid     = golden[n][14][CCIP_TID_WIDTH-1:0];
      mmio_req_valid = golden[n][15][0];
      mmio_req_tid   = golden[n][16][CCIP_TID_WIDTH-1:0];
   endtask

   task automatic check_line(input int n);
      check_value("error_code", 64'(error_code), golden[n][FIELD_ERR], n);
      check_value("sim_kill", 64'(sim_kill), golden[n][FIELD_KILL], n);
   endtask

   // Comment and blank lines skipped
   task automatic load_golden(output int count, output bit ok);
      int    fd;
      int    got;
      bit    bad;
      string text;
      count = 0;
      bad   = 1'b0;
      fd    = $fopen("verif/sniffer_golden.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && count < MAX_LINES) begin
            text = "";
            got  = $fgets(text, fd);
            if (got > 0 && text.len() > 1 && text.substr(0, 0) != "#") begin
               got = $sscanf(text,
                  "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  golden[count][0], golden[count][1], golden[count][2], golden[count][3],
                  golden[count][4], golden[count][5], golden[count][6], golden[count][7],
                  golden[count][8], golden[count][9], golden[count][10], golden[count][11],
                  golden[count][12], golden[count][13], golden[count][14],
                  golden[count][15], golden[count][16], golden[count][17],
                  golden[count][18]);
               if (got == NUM_FIELDS) begin
                  count++;
               end else begin
                  $display("malformed golden line: %s", text);
                  bad = 1'b1;
               end
            end
         end
         $fclose(fd);
      end
      ok = (count > 0) && !bad;
   endtask

   initial begin
      int line_count;
      bit load_ok;
      int n;
      drive_idle();
      ase_reset = 1'b1;
      load_golden(line_count, load_ok);
      if (!load_ok) begin
         $display("golden file missing or unreadable");
         $display("test failed");
         $finish;
      end else begin
         cycle_limit = line_count + SIMKILL_DELAY + 50;
         repeat (5) @(posedge clk);
         @(negedge clk);
         ase_reset = 1'b0;
         // Each row is checked two falling edges after it was applied
         for (n = 0; n < line_count + 2; n++) begin
            if (n >= 2) begin
               check_line(n - 2);
            end
            if (n < line_count) begin
               apply_line(n);
            end else begin
               drive_idle();
            end
            @(negedge clk);
         end
         $display("checks: %0d, errors: %0d", check_count, error_count);
         if (error_count == 0) begin
            $display("test passed");
         end else begin
            $display("test failed");
         end
         $finish;
      end
   end

endmodule

// ==== verif/sniffer_assertions.sv ====
`timescale 1ns/1ps

module sniffer_assertions import sniff_pkg::*; (
   input logic                          clk,
   input logic                          ase_reset,
   input logic [SNIFF_VECTOR_WIDTH-1:0] error_code,
   input logic                          sim_kill
);

   // Set once any fatal bit has been registered
   logic fatal_seen;

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         fatal_seen <= 1'b0;
      end else if ((error_code & ~SNIFF_WARN_MASK) != '0) begin
         fatal_seen <= 1'b1;
      end
   end

   // Error vector cleared by reset
   reset_clears_error: assert property (@(posedge clk) ase_reset |=> (error_code == '0))
      else $error("error_code not cleared after ase_reset");

   // Kill is sticky until reset
   kill_is_sticky: assert property (@(posedge clk) (sim_kill && !ase_reset) |=> sim_kill)
      else $error("sim_kill fell without ase_reset");

   // Warnings alone never kill
   kill_needs_fatal: assert property (@(posedge clk) disable iff (ase_reset)
                                      $rose(sim_kill) |-> fatal_seen)
      else $error("sim_kill rose with no fatal error registered");

endmodule

bind error_report sniffer_assertions u_assert (
   .clk(clk), .ase_reset(ase_reset), .error_code(error_code), .sim_kill(sim_kill)
);

// ==== design/ccip_sniffer_top.sv ====
`timescale 1ns/1ps

module ccip_sniffer_top import ccip_pkg::*; import sniff_pkg::*; (
   input  logic                          clk,
   input  logic                          ase_reset,
   input  logic                          soft_reset,
   input  logic                          c0_realfull,
   input  logic                          c1_realfull,
   input  logic                          c0_valid,
   input  logic [CCIP_REQ_WIDTH-1:0]     c0_req_type,
   input  logic [CCIP_CLLEN_WIDTH-1:0]   c0_cl_len,
   input  logic [CCIP_CLADDR_WIDTH-1:0]  c0_addr,
   input  logic                          c1_valid,
   input  logic [CCIP_REQ_WIDTH-1:0]     c1_req_type,
   input  logic [CCIP_CLLEN_WIDTH-1:0]   c1_cl_len,
   input  logic                          c1_sop,
   input  logic [CCIP_VC_WIDTH-1:0]      c1_vc_sel,
   input  logic [CCIP_CLADDR_WIDTH-1:0]  c1_addr,
   input  logic                          c2_rsp_valid,
   input  logic [CCIP_TID_WIDTH-1:0]     c2_rsp_tid,
   input  logic                          mmio_req_valid,
   input  logic [CCIP_TID_WIDTH-1:0]     mmio_req_tid,
   output logic [SNIFF_VECTOR_WIDTH-1:0] error_code,
   output logic                          sim_kill
);

   // Registered link
   logic                         d_soft_reset;
   logic                         d_c0_realfull;
   logic                         d_c1_realfull;
   logic                         d_c0_valid;
   logic [CCIP_CLLEN_WIDTH-1:0]  d_c0_cl_len;
   logic [CCIP_CLADDR_WIDTH-1:0] d_c0_addr;
   logic                         d_c1_valid;
   logic [CCIP_REQ_WIDTH-1:0]    d_c1_req_type;
   logic [CCIP_CLLEN_WIDTH-1:0]  d_c1_cl_len;
   logic                         d_c1_sop;
   logic [CCIP_VC_WIDTH-1:0]     d_c1_vc_sel;
   logic [CCIP_CLADDR_WIDTH-1:0] d_c1_addr;
   logic                         d_c2_rsp_valid;
   logic [CCIP_TID_WIDTH-1:0]    d_c2_rsp_tid;
   logic                         d_mmio_req_valid;
   logic [CCIP_TID_WIDTH-1:0]    d_mmio_req_tid;
   // Type classes
   logic                         d_c0_legal;
   logic                         d_c1_write;
   logic                         d_c1_fence;
   logic                         d_c1_legal;
   // Violation vectors
   logic [SNIFF_VECTOR_WIDTH-1:0] rule_err;
   logic [SNIFF_VECTOR_WIDTH-1:0] burst_err;
   logic [SNIFF_VECTOR_WIDTH-1:0] mmio_err;

   tx_decode u_decode (
      .clk(clk), .ase_reset(ase_reset), .soft_reset(soft_reset),
      .c0_realfull(c0_realfull), .c1_realfull(c1_realfull),
      .c0_valid(c0_valid), .c0_req_type(c0_req_type), .c0_cl_len(c0_cl_len),
      .c0_addr(c0_addr), .c1_valid(c1_valid), .c1_req_type(c1_req_type),
      .c1_cl_len(c1_cl_len), .c1_sop(c1_sop), .c1_vc_sel(c1_vc_sel), .c1_addr(c1_addr),
      .c2_rsp_valid(c2_rsp_valid), .c2_rsp_tid(c2_rsp_tid),
      .mmio_req_valid(mmio_req_valid), .mmio_req_tid(mmio_req_tid),
      .d_soft_reset(d_soft_reset), .d_c0_realfull(d_c0_realfull),
      .d_c1_realfull(d_c1_realfull), .d_c0_valid(d_c0_valid), .d_c0_cl_len(d_c0_cl_len),
      .d_c0_addr(d_c0_addr), .d_c1_valid(d_c1_valid), .d_c1_req_type(d_c1_req_type),
      .d_c1_cl_len(d_c1_cl_len), .d_c1_sop(d_c1_sop), .d_c1_vc_sel(d_c1_vc_sel),
      .d_c1_addr(d_c1_addr), .d_c2_rsp_valid(d_c2_rsp_valid), .d_c2_rsp_tid(d_c2_rsp_tid),
      .d_mmio_req_valid(d_mmio_req_valid), .d_mmio_req_tid(d_mmio_req_tid),
      .d_c0_legal(d_c0_legal), .d_c1_write(d_c1_write), .d_c1_fence(d_c1_fence),
      .d_c1_legal(d_c1_legal)
   );

   request_rule_check u_rules (
      .d_soft_reset(d_soft_reset), .d_c0_realfull(d_c0_realfull),
      .d_c1_realfull(d_c1_realfull), .d_c0_valid(d_c0_valid), .d_c0_legal(d_c0_legal),
      .d_c0_cl_len(d_c0_cl_len), .d_c0_addr(d_c0_addr), .d_c1_valid(d_c1_valid),
      .d_c1_legal(d_c1_legal), .d_c2_rsp_valid(d_c2_rsp_valid), .rule_err(rule_err)
   );

   c1_burst_check u_burst (
      .clk(clk), .ase_reset(ase_reset), .d_c1_valid(d_c1_valid), .d_c1_write(d_c1_write),
      .d_c1_fence(d_c1_fence), .d_c1_sop(d_c1_sop), .d_c1_cl_len(d_c1_cl_len),
      .d_c1_vc_sel(d_c1_vc_sel), .d_c1_req_type(d_c1_req_type), .d_c1_addr(d_c1_addr),
      .burst_err(burst_err)
   );

   mmio_tracker u_mmio (
      .clk(clk), .ase_reset(ase_reset), .d_mmio_req_valid(d_mmio_req_valid),
      .d_mmio_req_tid(d_mmio_req_tid), .d_c2_rsp_valid(d_c2_rsp_valid),
      .d_c2_rsp_tid(d_c2_rsp_tid), .mmio_err(mmio_err)
   );

   error_report u_report (
      .clk(clk), .ase_reset(ase_reset), .rule_err(rule_err), .burst_err(burst_err),
      .mmio_err(mmio_err), .error_code(error_code), .sim_kill(sim_kill)
   );

endmodule

// ==== design/error_report.sv ====
`timescale 1ns/1ps

module error_report import sniff_pkg::*; (
   input  logic                          clk,
   input  logic                          ase_reset,
   input  logic [SNIFF_VECTOR_WIDTH-1:0] rule_err,
   input  logic [SNIFF_VECTOR_WIDTH-1:0] burst_err,
   input  logic [SNIFF_VECTOR_WIDTH-1:0] mmio_err,
   output logic [SNIFF_VECTOR_WIDTH-1:0] error_code,
   output logic                          sim_kill
);

   logic [SNIFF_VECTOR_WIDTH-1:0] err_next;
   logic                          fatal_next;
   logic                          kill_armed;
   logic [SIMKILL_CNT_WIDTH-1:0]  kill_cnt;

   // Execute vectors never overlap
   assign err_next   = rule_err | burst_err | mmio_err;
   assign fatal_next = |(err_next & ~SNIFF_WARN_MASK);

   // One-cycle pulses
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         error_code <= '0;
      end else begin
         error_code <= err_next;
      end
   end

   // Kill countdown, armed on the edge the first fatal bit registers
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         kill_armed <= 1'b0;
         kill_cnt   <= '0;
         sim_kill   <= 1'b0;
      end else if (!kill_armed) begin
         if (fatal_next) begin
            kill_armed <= 1'b1;
            kill_cnt   <= SIMKILL_CNT_WIDTH'(SIMKILL_DELAY - 1);
         end
      end else if (!sim_kill) begin
         // Sticky once set
         if (kill_cnt == '0) begin
            sim_kill <= 1'b1;
         end else begin
            kill_cnt <= kill_cnt - SIMKILL_CNT_WIDTH'(1);
         end
      end
   end

endmodule

// ==== design/mmio_tracker.sv ====
`timescale 1ns/1ps

module mmio_tracker import ccip_pkg::*; import sniff_pkg::*; (
   input  logic                          clk,
   input  logic                          ase_reset,
   input  logic                          d_mmio_req_valid,
   input  logic [CCIP_TID_WIDTH-1:0]     d_mmio_req_tid,
   input  logic                          d_c2_rsp_valid,
   input  logic [CCIP_TID_WIDTH-1:0]     d_c2_rsp_tid,
   output logic [SNIFF_VECTOR_WIDTH-1:0] mmio_err
);

   // One flag of each per TID
   logic [2**CCIP_TID_WIDTH-1:0] active;
   logic [2**CCIP_TID_WIDTH-1:0] fire;

   for (genvar ii = 0; ii < 2**CCIP_TID_WIDTH; ii++) begin : g_entry
      logic                        entry_active;
      logic                        entry_fired;
      logic [MMIO_TIMER_WIDTH-1:0] entry_timer;
      logic                        req_hit;
      logic                        rsp_hit;

      assign req_hit = d_mmio_req_valid & (d_mmio_req_tid == CCIP_TID_WIDTH'(ii));
      assign rsp_hit = d_c2_rsp_valid & (d_c2_rsp_tid == CCIP_TID_WIDTH'(ii));

      assign active[ii] = entry_active;
      // Timer reads T-1 in the Tth active cycle
      assign fire[ii] = entry_active & ~entry_fired &
                        (entry_timer == MMIO_TIMER_WIDTH'(MMIO_RESPONSE_TIMEOUT - 1));

      always_ff @(posedge clk) begin
         if (ase_reset) begin
            entry_active <= 1'b0;
            entry_fired  <= 1'b0;
            entry_timer  <= '0;
         end else if (req_hit) begin
            // New request restarts the entry
            entry_active <= 1'b1;
            entry_fired  <= 1'b0;
            entry_timer  <= '0;
         end else if (rsp_hit) begin
            // Late responses also retire quietly
            entry_active <= 1'b0;
            entry_fired  <= 1'b0;
            entry_timer  <= '0;
         end else if (entry_active && !entry_fired) begin
            entry_timer <= entry_timer + MMIO_TIMER_WIDTH'(1);
            entry_fired <= fire[ii];
         end
      end
   end

   always_comb begin
      mmio_err = '0;
      // One pulse per timed-out request
      mmio_err[MMIO_TIMEOUT]     = |fire;
      // Response with nothing outstanding on its TID
      mmio_err[MMIO_UNSOLICITED] = d_c2_rsp_valid & ~active[d_c2_rsp_tid];
   end

endmodule

// ==== design/c1_burst_check.sv ====
`timescale 1ns/1ps

module c1_burst_check import ccip_pkg::*; import sniff_pkg::*; (
   input  logic                          clk,
   input  logic                          ase_reset,
   input  logic                          d_c1_valid,
   input  logic                          d_c1_write,
   input  logic                          d_c1_fence,
   input  logic                          d_c1_sop,
   input  logic [CCIP_CLLEN_WIDTH-1:0]   d_c1_cl_len,
   input  logic [CCIP_VC_WIDTH-1:0]      d_c1_vc_sel,
   input  logic [CCIP_REQ_WIDTH-1:0]     d_c1_req_type,
   input  logic [CCIP_CLADDR_WIDTH-1:0]  d_c1_addr,
   output logic [SNIFF_VECTOR_WIDTH-1:0] burst_err
);

   // Beat index expected next minus one, zero when idle
   logic [CCIP_CLLEN_WIDTH-1:0] exp_beat;

   // Burst base, captured on the sop beat
   logic [CCIP_VC_WIDTH-1:0]    base_vc;
   logic [CCIP_REQ_WIDTH-1:0]   base_type;
   logic [1:0]                  base_addr_low2;
   logic [CCIP_CLLEN_WIDTH-1:0] base_len;

   logic       in_burst;
   logic       wr_beat;
   logic       fence_beat;
   logic       burst_start;
   logic       burst_last;
   logic [1:0] exp_addr_low2;

   assign in_burst   = (exp_beat != '0);
   assign wr_beat    = d_c1_valid & d_c1_write;
   assign fence_beat = d_c1_valid & d_c1_fence;

   // Only 2-line and 4-line sop writes open a burst
   assign burst_start = ~in_burst & wr_beat & d_c1_sop &
                        ((d_c1_cl_len == CL_LEN_2) | (d_c1_cl_len == CL_LEN_4));

   // Length code equals the index of the last beat
   assign burst_last    = (exp_beat == base_len);
   assign exp_addr_low2 = base_addr_low2 + exp_beat;

   always_comb begin
      burst_err = '0;
      if (!in_burst) begin
         // First line of a request
         burst_err[C1_SOP_NOT_SET] = wr_beat & ~d_c1_sop;
         burst_err[C1_3CL]         = wr_beat & d_c1_sop & (d_c1_cl_len == CL_LEN_3);
         burst_err[C1_ALIGN2]      = wr_beat & d_c1_sop & (d_c1_cl_len == CL_LEN_2) &
                                     d_c1_addr[0];
         burst_err[C1_ALIGN4]      = wr_beat & d_c1_sop & (d_c1_cl_len == CL_LEN_4) &
                                     (d_c1_addr[1:0] != 2'b00);
         // Warning only
         burst_err[C1_ADDR_ZERO]   = wr_beat & (d_c1_addr == '0);
      end else begin
         // Beats 2 to 4 must follow the base
         burst_err[C1_FENCE_IN_BURST] = fence_beat;
         burst_err[C1_SOP_IN_BURST]   = wr_beat & d_c1_sop;
         burst_err[C1_UNEXP_VCSEL]    = wr_beat & (d_c1_vc_sel != base_vc);
         burst_err[C1_UNEXP_REQTYPE]  = wr_beat & (d_c1_req_type != base_type);
         burst_err[C1_UNEXP_ADDR]     = wr_beat & (d_c1_addr[1:0] != exp_addr_low2);
      end
   end

   // Burst position
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         exp_beat <= '0;
      end else if (burst_start) begin
         exp_beat <= CCIP_CLLEN_WIDTH'(1);
      end else if (in_burst && wr_beat) begin
         // A fence holds the position
         exp_beat <= burst_last ? '0 : exp_beat + CCIP_CLLEN_WIDTH'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (burst_start) begin
         base_vc        <= d_c1_vc_sel;
         base_type      <= d_c1_req_type;
         base_addr_low2 <= d_c1_addr[1:0];
         base_len       <= d_c1_cl_len;
      end
   end

endmodule

// ==== design/request_rule_check.sv ====
`timescale 1ns/1ps

module request_rule_check import ccip_pkg::*; import sniff_pkg::*; (
   input  logic                          d_soft_reset,
   input  logic                          d_c0_realfull,
   input  logic                          d_c1_realfull,
   input  logic                          d_c0_valid,
   input  logic                          d_c0_legal,
   input  logic [CCIP_CLLEN_WIDTH-1:0]   d_c0_cl_len,
   input  logic [CCIP_CLADDR_WIDTH-1:0]  d_c0_addr,
   input  logic                          d_c1_valid,
   input  logic                          d_c1_legal,
   input  logic                          d_c2_rsp_valid,
   output logic [SNIFF_VECTOR_WIDTH-1:0] rule_err
);

   // Legal read beat, gates the length and address checks
   logic c0_read;

   assign c0_read = d_c0_valid & d_c0_legal;

   always_comb begin
      rule_err = '0;

      // c0 beat level checks
      rule_err[C0_INVALID_REQTYPE] = d_c0_valid & ~d_c0_legal;
      rule_err[C0_OVERFLOW]        = d_c0_valid & d_c0_realfull;
      rule_err[C0_RESET_IGNORED]   = d_c0_valid & d_soft_reset;

      // Length and alignment, legal reads only
      rule_err[C0_3CL]    = c0_read & (d_c0_cl_len == CL_LEN_3);
      rule_err[C0_ALIGN2] = c0_read & (d_c0_cl_len == CL_LEN_2) & d_c0_addr[0];
      rule_err[C0_ALIGN4] = c0_read & (d_c0_cl_len == CL_LEN_4) & (d_c0_addr[1:0] != 2'b00);
      // Zero address only warns
      rule_err[C0_ADDR_ZERO] = c0_read & (d_c0_addr == '0);

      // c1 checks outside the burst machine
      rule_err[C1_INVALID_REQTYPE] = d_c1_valid & ~d_c1_legal;
      rule_err[C1_OVERFLOW]        = d_c1_valid & d_c1_realfull;
      rule_err[C1_RESET_IGNORED]   = d_c1_valid & d_soft_reset;

      // MMIO response during AFU reset
      rule_err[MMIO_RESET_IGNORED] = d_c2_rsp_valid & d_soft_reset;
   end

endmodule

// ==== design/tx_decode.sv ====
`timescale 1ns/1ps

module tx_decode import ccip_pkg::*; (
   input  logic                         clk,
   input  logic                         ase_reset,
   input  logic                         soft_reset,
   input  logic                         c0_realfull,
   input  logic                         c1_realfull,
   input  logic                         c0_valid,
   input  logic [CCIP_REQ_WIDTH-1:0]    c0_req_type,
   input  logic [CCIP_CLLEN_WIDTH-1:0]  c0_cl_len,
   input  logic [CCIP_CLADDR_WIDTH-1:0] c0_addr,
   input  logic                         c1_valid,
   input  logic [CCIP_REQ_WIDTH-1:0]    c1_req_type,
   input  logic [CCIP_CLLEN_WIDTH-1:0]  c1_cl_len,
   input  logic                         c1_sop,
   input  logic [CCIP_VC_WIDTH-1:0]     c1_vc_sel,
   input  logic [CCIP_CLADDR_WIDTH-1:0] c1_addr,
   input  logic                         c2_rsp_valid,
   input  logic [CCIP_TID_WIDTH-1:0]    c2_rsp_tid,
   input  logic                         mmio_req_valid,
   input  logic [CCIP_TID_WIDTH-1:0]    mmio_req_tid,
   output logic                         d_soft_reset,
   output logic                         d_c0_realfull,
   output logic                         d_c1_realfull,
   output logic                         d_c0_valid,
   output logic [CCIP_CLLEN_WIDTH-1:0]  d_c0_cl_len,
   output logic [CCIP_CLADDR_WIDTH-1:0] d_c0_addr,
   output logic                         d_c1_valid,
   output logic [CCIP_REQ_WIDTH-1:0]    d_c1_req_type,
   output logic [CCIP_CLLEN_WIDTH-1:0]  d_c1_cl_len,
   output logic                         d_c1_sop,
   output logic [CCIP_VC_WIDTH-1:0]     d_c1_vc_sel,
   output logic [CCIP_CLADDR_WIDTH-1:0] d_c1_addr,
   output logic                         d_c2_rsp_valid,
   output logic [CCIP_TID_WIDTH-1:0]    d_c2_rsp_tid,
   output logic                         d_mmio_req_valid,
   output logic [CCIP_TID_WIDTH-1:0]    d_mmio_req_tid,
   output logic                         d_c0_legal,
   output logic                         d_c1_write,
   output logic                         d_c1_fence,
   output logic                         d_c1_legal
);

   // Only the classified read type is needed downstream
   logic [CCIP_REQ_WIDTH-1:0] d_c0_req_type;

   // Beat qualifiers
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         d_c0_valid       <= 1'b0;
         d_c1_valid       <= 1'b0;
         d_c2_rsp_valid   <= 1'b0;
         d_mmio_req_valid <= 1'b0;
      end else begin
         d_c0_valid       <= c0_valid;
         d_c1_valid       <= c1_valid;
         d_c2_rsp_valid   <= c2_rsp_valid;
         d_mmio_req_valid <= mmio_req_valid;
      end
   end

   // Payload and side-band copies
   always_ff @(posedge clk) begin
      d_soft_reset   <= soft_reset;
      d_c0_realfull  <= c0_realfull;
      d_c1_realfull  <= c1_realfull;
      d_c0_req_type  <= c0_req_type;
      d_c0_cl_len    <= c0_cl_len;
      d_c0_addr      <= c0_addr;
      d_c1_req_type  <= c1_req_type;
      d_c1_cl_len    <= c1_cl_len;
      d_c1_sop       <= c1_sop;
      d_c1_vc_sel    <= c1_vc_sel;
      d_c1_addr      <= c1_addr;
      d_c2_rsp_tid   <= c2_rsp_tid;
      d_mmio_req_tid <= mmio_req_tid;
   end

   // Request type classes
   assign d_c0_legal = (d_c0_req_type == REQ_RDLINE_I) || (d_c0_req_type == REQ_RDLINE_S);
   assign d_c1_write = (d_c1_req_type == REQ_WRLINE_I) || (d_c1_req_type == REQ_WRLINE_M) ||
                       (d_c1_req_type == REQ_WRPUSH_I);
   assign d_c1_fence = (d_c1_req_type == REQ_WRFENCE);
   // Fence counts as legal on c1
   assign d_c1_legal = d_c1_write | d_c1_fence;

endmodule

// ==== design/sniff_pkg.sv ====
package sniff_pkg;

   localparam int SNIFF_VECTOR_WIDTH = 23;

   // c0 request errors
   localparam int C0_INVALID_REQTYPE = 0;
   localparam int C0_OVERFLOW        = 1;
   localparam int C0_ALIGN2          = 2;
   localparam int C0_ALIGN4          = 3;
   localparam int C0_RESET_IGNORED   = 4;
   localparam int C0_3CL             = 5;
   localparam int C0_ADDR_ZERO       = 6;

   // c1 request and burst errors
   localparam int C1_INVALID_REQTYPE = 7;
   localparam int C1_OVERFLOW        = 8;
   localparam int C1_ALIGN2          = 9;
   localparam int C1_ALIGN4          = 10;
   localparam int C1_RESET_IGNORED   = 11;
   localparam int C1_UNEXP_VCSEL     = 12;
   localparam int C1_UNEXP_ADDR      = 13;
   localparam int C1_UNEXP_REQTYPE   = 14;
   localparam int C1_SOP_NOT_SET     = 15;
   localparam int C1_SOP_IN_BURST    = 16;
   localparam int C1_3CL             = 17;
   localparam int C1_FENCE_IN_BURST  = 18;
   localparam int C1_ADDR_ZERO       = 19;

   // MMIO response errors
   localparam int MMIO_TIMEOUT       = 20;
   localparam int MMIO_UNSOLICITED   = 21;
   localparam int MMIO_RESET_IGNORED = 22;

   // Warning-only bits, never start the kill countdown
   localparam logic [SNIFF_VECTOR_WIDTH-1:0] SNIFF_WARN_MASK =
      (SNIFF_VECTOR_WIDTH'(1) << C0_RESET_IGNORED)   |
      (SNIFF_VECTOR_WIDTH'(1) << C1_RESET_IGNORED)   |
      (SNIFF_VECTOR_WIDTH'(1) << MMIO_RESET_IGNORED) |
      (SNIFF_VECTOR_WIDTH'(1) << C0_ADDR_ZERO)       |
      (SNIFF_VECTOR_WIDTH'(1) << C1_ADDR_ZERO)       |
      (SNIFF_VECTOR_WIDTH'(1) << C1_UNEXP_VCSEL);

   // Timing constants
   localparam int MMIO_RESPONSE_TIMEOUT = 16;
   localparam int MMIO_TIMER_WIDTH      = 5;
   localparam int SIMKILL_DELAY         = 20;
   localparam int SIMKILL_CNT_WIDTH     = 5;

endpackage

// ==== design/ccip_pkg.sv ====
package ccip_pkg;

   // Link field widths
   localparam int CCIP_CLADDR_WIDTH = 42;
   localparam int CCIP_REQ_WIDTH    = 4;
   localparam int CCIP_CLLEN_WIDTH  = 2;
   localparam int CCIP_VC_WIDTH     = 2;
   // MMIO transaction ID, kept narrow for the tracker
   localparam int CCIP_TID_WIDTH    = 4;

   // Legal c0 read codes
   localparam logic [CCIP_REQ_WIDTH-1:0] REQ_RDLINE_I = 4'h0;
   localparam logic [CCIP_REQ_WIDTH-1:0] REQ_RDLINE_S = 4'h1;

   // c1 write and fence codes
   localparam logic [CCIP_REQ_WIDTH-1:0] REQ_WRLINE_I = 4'h0;
   localparam logic [CCIP_REQ_WIDTH-1:0] REQ_WRLINE_M = 4'h1;
   localparam logic [CCIP_REQ_WIDTH-1:0] REQ_WRPUSH_I = 4'h2;
   localparam logic [CCIP_REQ_WIDTH-1:0] REQ_WRFENCE  = 4'h4;

   // Length code is line count minus one, 3CL is illegal
   localparam logic [CCIP_CLLEN_WIDTH-1:0] CL_LEN_1 = 2'd0;
   localparam logic [CCIP_CLLEN_WIDTH-1:0] CL_LEN_2 = 2'd1;
   localparam logic [CCIP_CLLEN_WIDTH-1:0] CL_LEN_3 = 2'd2;
   localparam logic [CCIP_CLLEN_WIDTH-1:0] CL_LEN_4 = 2'd3;

endpackage
